//--- verif/credit_buffer_testdata.txt
// W <word hex> <idle cycles after the word>
// H <word index> <cycles without downstream credit once that word is out>
W 1a2b 3
W 3c4d 1
W 5e6f 0
W 7081 0
W 92a3 0
W b4c5 0
W d6e7 0
W f809 0
W 0a1b 0
W 2c3d 0
W 4e5f 0
W 6071 0
W 8293 0
W a4b5 0
W c6d7 2
W e8f9 0
W 0102 5
W fedc 0
W ba98 1
W 7654 0
W 3210 4
W ffff 0
W 0000 2
W a5a5 0
H 1 60
H 14 12

//--- verilog.f
verilog/buffer_pkg.sv
verilog/fifo_read_if.sv
verilog/dual_port_ram.sv
verilog/fifo_ctrl.sv
verilog/credit_sender.sv
verilog/credit_buffer_top.sv
verif/buffer_sva.sv
verif/buffer_checker.sv
verif/tb_credit_buffer.sv

//--- Bender.yml
package:
  name: credit_buffer

sources:
  - files:
      - verilog/buffer_pkg.sv
      - verilog/fifo_read_if.sv
      - verilog/dual_port_ram.sv
      - verilog/fifo_ctrl.sv
      - verilog/credit_sender.sv
      - verilog/credit_buffer_top.sv
  - target: test
    files:
      - verif/buffer_sva.sv
      - verif/buffer_checker.sv
      - verif/tb_credit_buffer.sv

//--- verif/tb_credit_buffer.sv
`timescale 1ns/1ps

module tb_credit_buffer;

	localparam int    max_words = 64;
	localparam string data_file = "verif/credit_buffer_testdata.txt";

	logic              clock;
	logic              reset;
	logic              in_valid;
	buffer_pkg::word_t in_data;
	logic              in_credit;
	logic              out_valid;
	buffer_pkg::word_t out_data;
	logic              out_credit;

	// Stimulus from the data file
	buffer_pkg::word_t words [max_words];
	int                idle_after [max_words];
	int                hold_after [max_words];
	int                n_words;
	int                hold_total;

	// Shared with the checker
	int   up_credit;
	logic holding;
	logic finish_check;
	int   data_errors;
	int   credit_errors;
	int   words_out;

	logic [31:0] lfsr_state;

	//////////////////////////////
	// Clock and instances
	//////////////////////////////

	initial clock = 1'b0;
	always #5 clock = ~clock;

	credit_buffer_top UUT (
		.clock      (clock),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_credit (out_credit)
	);

	buffer_checker monitor (
		.clock         (clock),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_credit     (in_credit),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_credit    (out_credit),
		.holding       (holding),
		.finish_check  (finish_check),
		.up_credit     (up_credit),
		.data_errors   (data_errors),
		.credit_errors (credit_errors),
		.words_out     (words_out)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// W lines give word and idle gap, H lines give index and hold length
	function automatic bit load_testdata();
		int    fd;
		int    a;
		int    b;
		string line;
		n_words    = 0;
		hold_total = 0;
		fd = $fopen(data_file, "r");
		if (fd == 0) begin
			return 1'b0;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line[0] == "W") begin
				if ($sscanf(line.substr(1, line.len() - 1), "%h %d", a, b) == 2
						&& n_words < max_words) begin
					words[n_words]      = buffer_pkg::word_t'(a);
					idle_after[n_words] = b;
					n_words++;
				end
			end else if (line.len() > 1 && line[0] == "H") begin
				if ($sscanf(line.substr(1, line.len() - 1), "%d %d", a, b) == 2
						&& a >= 0 && a < max_words) begin
					hold_after[a] = b;
					hold_total += b;
				end
			end
		end
		$fclose(fd);
		return n_words > 0;
	endfunction

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic int take_bits(input int n);
		int value;
		int i;
		value = 0;
		for (i = 0; i < n; i++) begin
			lfsr_state = {lfsr_state[30:0],
				lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
			value = (value << 1) | lfsr_state[0];
		end
		return value;
	endfunction

	// Upstream sender spends one credit per word
	task automatic drive_upstream();
		int next;
		int idle_left;
		next      = 0;
		idle_left = 0;
		forever begin
			@(posedge clock);
			#1;
			if (in_credit) begin
				up_credit++;
			end
			in_valid = 1'b0;
			if (idle_left > 0) begin
				idle_left--;
			end else if (next < n_words && up_credit > 0) begin
				in_valid  = 1'b1;
				in_data   = words[next];
				up_credit--;
				idle_left = idle_after[next];
				next++;
			end
		end
	endtask

	// Downstream receiver returns credits after 1 to 4 cycles
	task automatic return_credits();
		int pending [$];
		int hold_left;
		int seen;
		int i;
		hold_left = 0;
		seen      = 0;
		forever begin
			@(posedge clock);
			#1;
			out_credit = 1'b0;
			if (hold_left > 0) begin
				hold_left--;
			end
			for (i = 0; i < pending.size(); i++) begin
				if (pending[i] > 0) begin
					pending[i]--;
				end
			end
			if (out_valid) begin
				pending.push_back(1 + take_bits(2));
				if (seen < max_words && hold_after[seen] > 0) begin
					hold_left = hold_after[seen];
				end
				seen++;
			end
			holding = hold_left > 0;
			// Oldest credit first and only one per cycle
			if (!holding && pending.size() > 0 && pending[0] == 0) begin
				out_credit = 1'b1;
				void'(pending.pop_front());
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		reset        = 1'b1;
		in_valid     = 1'b0;
		in_data      = '0;
		out_credit   = 1'b0;
		holding      = 1'b0;
		finish_check = 1'b0;
		up_credit    = buffer_pkg::fifo_depth;
		lfsr_state   = 32'hc5c9;
		if (!load_testdata()) begin
			$display("Could not read any words from %s", data_file);
			$display("TEST FAILED");
			$finish;
		end else begin
			repeat (16) @(posedge clock);
			#1;
			reset = 1'b0;
			fork
				drive_upstream();
				return_credits();
				begin
					// Watchdog
					repeat (40 * n_words + hold_total) @(posedge clock);
					$display("The stream did not finish, %0d of %0d words came out",
						words_out, n_words);
					$display("TEST FAILED");
					$finish;
				end
			join_none
			wait (words_out == n_words);
			repeat (3) @(posedge clock);
			#1;
			finish_check = 1'b1;
			@(posedge clock);
			#1;
			$display("Errors: %0d data, %0d credit, %0d assertion",
				data_errors, credit_errors, UUT.ctrl.fifo_checks.failures);
			if (data_errors == 0 && credit_errors == 0
					&& UUT.ctrl.fifo_checks.failures == 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

endmodule

//--- verif/buffer_checker.sv
`timescale 1ns/1ps

module buffer_checker (
	input  logic              clock,
	input  logic              reset,
	input  logic              in_valid,
	input  logic              in_credit,
	input  logic              out_valid,
	input  buffer_pkg::word_t out_data,
	input  logic              out_credit,
	input  logic              holding,
	input  logic              finish_check,
	input  int                up_credit,
	output int                data_errors,
	output int                credit_errors,
	output int                words_out
);

	// Expected words in file order
	buffer_pkg::word_t expected [$];

	int    fd;
	int    a;
	int    b;
	string line;

	// Running counts
	int   words_in;
	int   credits_in;
	int   credits_back;
	int   hold_words;
	logic first_sent;
	logic final_done;

	//////////////////////////////
	// Word list
	//////////////////////////////

	initial begin
		data_errors   = 0;
		credit_errors = 0;
		words_out     = 0;
		words_in      = 0;
		credits_in    = 0;
		credits_back  = 0;
		hold_words    = 0;
		first_sent    = 1'b0;
		final_done    = 1'b0;
		fd = $fopen("verif/credit_buffer_testdata.txt", "r");
		if (fd == 0) begin
			$display("Checker could not open the test data file");
			data_errors = 1;
		end else begin
			// Only W lines carry words
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] == "W") begin
					if ($sscanf(line.substr(1, line.len() - 1), "%h %d", a, b) == 2) begin
						expected.push_back(buffer_pkg::word_t'(a));
					end
				end
			end
			$fclose(fd);
		end
	end

	//////////////////////////////
	// Per-cycle checks
	//////////////////////////////

	always @(posedge clock) begin
		if (!reset) begin
			// Quiet outputs until the first word goes in
			if (!first_sent && (out_valid || in_credit)) begin
				$display("Output activity at %0t before any word was sent", $time);
				credit_errors++;
			end
			if (in_valid) begin
				first_sent = 1'b1;
				words_in++;
			end
			if (in_credit) begin
				credits_in++;
			end
			if (up_credit < 0 || up_credit > buffer_pkg::fifo_depth) begin
				$display("Upstream credit count left its range at %0t: %0d", $time, up_credit);
				credit_errors++;
			end
			if (out_credit) begin
				credits_back++;
			end
			if (out_valid) begin
				if (words_out >= expected.size()) begin
					$display("Extra word %h on out_data at %0t", out_data, $time);
					data_errors++;
				end else if (out_data !== expected[words_out]) begin
					$display("error %0t out_data expected %h actual %h",
						$time, expected[words_out], out_data);
					data_errors++;
				end
				words_out++;
				// Never more words than credits granted
				if (words_out > buffer_pkg::out_credits + credits_back) begin
					$display("error %0t out_valid count expected <= %0d actual %0d",
						$time, buffer_pkg::out_credits + credits_back, words_out);
					credit_errors++;
				end
				// Trigger word of the window counts too
				if (holding) begin
					hold_words++;
					if (hold_words > buffer_pkg::out_credits) begin
						$display("error %0t out_valid in hold expected <= %0d actual %0d",
							$time, buffer_pkg::out_credits, hold_words);
						credit_errors++;
					end
				end
			end
			if (!holding) begin
				hold_words = 0;
			end
			// End of stream totals
			if (finish_check && !final_done) begin
				final_done = 1'b1;
				if (credits_in != words_in) begin
					$display("error %0t in_credit pulses expected %0d actual %0d",
						$time, words_in, credits_in);
					credit_errors++;
				end
				if (up_credit != buffer_pkg::fifo_depth) begin
					$display("error %0t up_credit expected %0d actual %0d",
						$time, buffer_pkg::fifo_depth, up_credit);
					credit_errors++;
				end
				if (words_in != expected.size()) begin
					$display("Only %0d of %0d words were sent", words_in, expected.size());
					data_errors++;
				end
			end
		end
	end

endmodule

//--- verif/buffer_sva.sv
`timescale 1ns/1ps

module buffer_sva (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input logic full,
	input logic empty,
	input logic pop,
	input logic rd_valid
);

	// Count of failed properties
	int failures;

	initial failures = 0;

	//////////////////////////////
	// FIFO controller properties
	//////////////////////////////

	// Upstream credit keeps writes off a full FIFO
	no_write_when_full: assert property (@(posedge clock) disable iff (reset)
		in_valid |-> !full)
		else begin
			$error("in_valid seen while the FIFO is full");
			failures++;
		end

	// Sender only pops what it can see
	no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
		pop |-> !empty)
		else begin
			$error("pop seen while the FIFO is empty");
			failures++;
		end

	// Read data one cycle after each pop
	read_after_pop: assert property (@(posedge clock) disable iff (reset)
		pop |=> rd_valid)
		else begin
			$error("rd_valid missing one cycle after pop");
			failures++;
		end

endmodule

// Attached to every FIFO controller
bind fifo_ctrl buffer_sva fifo_checks (
	.clock    (clock),
	.reset    (reset),
	.in_valid (in_valid),
	.full     (full),
	.empty    (empty),
	.pop      (rd.pop),
	.rd_valid (read_q)
);

//--- verilog/credit_buffer_top.sv
`timescale 1ns/1ps

module credit_buffer_top (
	input  logic              clock,
	input  logic              reset,

	// Upstream
	input  logic              in_valid,
	input  buffer_pkg::word_t in_data,
	output logic              in_credit,

	// Downstream
	output logic              out_valid,
	output buffer_pkg::word_t out_data,
	input  logic              out_credit
);

	//////////////////////////////
	// Internal read path
	//////////////////////////////

	// Pop, empty and read data between FIFO and sender
	fifo_read_if rd_bus ();

	//////////////////////////////
	// Circular FIFO
	//////////////////////////////

	// Write stage, pointers, RAM, upstream credit return
	fifo_ctrl ctrl (
		.clock     (clock),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_credit (in_credit),
		.rd        (rd_bus.ctrl)
	);

	//////////////////////////////
	// Downstream sender
	//////////////////////////////

	// Credit count, pops, output register
	credit_sender sender (
		.clock      (clock),
		.reset      (reset),
		.out_credit (out_credit),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.rd         (rd_bus.sender)
	);

endmodule

//--- verilog/credit_sender.sv
`timescale 1ns/1ps

module credit_sender (
	input  logic              clock,
	input  logic              reset,
	input  logic              out_credit,
	output logic              out_valid,
	output buffer_pkg::word_t out_data,
	fifo_read_if.sender       rd
);

	// Downstream credit held
	buffer_pkg::credit_t credit_q;
	buffer_pkg::credit_t credit_next;

	// Pops issued but not yet charged
	buffer_pkg::credit_t in_flight;

	// Registered pop request
	logic pop_q;
	logic pop_next;

	//////////////////////////////
	// Credit count
	//////////////////////////////

	// Pop on the bus this cycle is charged at this edge
	assign in_flight = buffer_pkg::credit_t'(pop_q);

	// Spend and return may meet in one cycle
	// a returned credit is usable next cycle
	assign credit_next = credit_q
		- in_flight
		+ buffer_pkg::credit_t'(out_credit);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			credit_q <= buffer_pkg::credit_t'(buffer_pkg::out_credits);
		end else begin
			credit_q <= credit_next;
		end
	end

	//////////////////////////////
	// Pop request
	//////////////////////////////

	// empty only lags a pop by the edge it is taken at
	// so a pop on the bus may be taking the last visible entry
	// and no second pop goes out behind it
	assign pop_next = !rd.empty
		&& (credit_q > in_flight)
		&& !pop_q;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pop_q <= 1'b0;
		end else begin
			pop_q <= pop_next;
		end
	end

	assign rd.pop = pop_q;

	//////////////////////////////
	// Output register
	//////////////////////////////

	// Strobe, one cycle per word, two after the pop
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= rd.rd_valid;
		end
	end

	// Word held until the next read
	always_ff @(posedge clock) begin
		if (rd.rd_valid) begin
			out_data <= rd.rd_data;
		end
	end

endmodule

//--- verilog/fifo_ctrl.sv
`timescale 1ns/1ps

module fifo_ctrl (
	input  logic              clock,
	input  logic              reset,
	input  logic              in_valid,
	input  buffer_pkg::word_t in_data,
	output logic              in_credit,
	fifo_read_if.ctrl         rd
);

	// Write stage
	logic              wr_valid_q;
	buffer_pkg::word_t wr_data_q;
	logic              wr_en;

	// Circular pointers, wrap bit on top
	buffer_pkg::ptr_t  rear_ptr;
	buffer_pkg::ptr_t  front_ptr;
	buffer_pkg::addr_t rear_addr;
	buffer_pkg::addr_t front_addr;
	logic              rear_wrap;
	logic              front_wrap;

	// Flags
	logic              empty;
	logic              full;

	// Read issue
	logic              pop_fire;
	logic              read_q;

	//////////////////////////////
	// Pointer fields
	//////////////////////////////

	assign rear_addr  = rear_ptr[buffer_pkg::addr_width-1:0];
	assign front_addr = front_ptr[buffer_pkg::addr_width-1:0];
	assign rear_wrap  = rear_ptr[buffer_pkg::addr_width];
	assign front_wrap = front_ptr[buffer_pkg::addr_width];

	//////////////////////////////
	// Flags
	//////////////////////////////

	// Word in the write stage already counts as present
	// so empty falls the cycle after in_valid
	assign empty = (rear_ptr == front_ptr) && !wr_valid_q;

	// Same slot, other lap, all sixteen slots hold data
	assign full = (rear_addr == front_addr) && (rear_wrap != front_wrap);

	//////////////////////////////
	// Write stage
	//////////////////////////////

	// Control half, cleared on reset
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_valid_q <= 1'b0;
		end else begin
			wr_valid_q <= in_valid;
		end
	end

	// Payload half, follows in_valid only
	always_ff @(posedge clock) begin
		if (in_valid) begin
			wr_data_q <= in_data;
		end
	end

	// Overflow guard, upstream credit keeps this from ever blocking
	assign wr_en = wr_valid_q && !full;

	// Rear moves with each committed write
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			rear_ptr <= '0;
		end else if (wr_en) begin
			rear_ptr <= rear_ptr + buffer_pkg::ptr_t'(1);
		end
	end

	//////////////////////////////
	// Read issue
	//////////////////////////////

	// Sender raises pop only with empty low, every such pop taken
	// Its registered pop lands after the write stage has committed
	assign pop_fire = rd.pop && !empty;

	// Front moves with each accepted pop
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			front_ptr <= '0;
		end else if (pop_fire) begin
			front_ptr <= front_ptr + buffer_pkg::ptr_t'(1);
		end
	end

	// One cycle after the pop: data valid, slot freed upstream
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			read_q <= 1'b0;
		end else begin
			read_q <= pop_fire;
		end
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	dual_port_ram ram (
		.clock   (clock),
		.wr_en   (wr_en),
		.wr_addr (rear_addr),
		.wr_data (wr_data_q),
		.rd_en   (pop_fire),
		.rd_addr (front_addr),
		.rd_data (rd.rd_data)
	);

	//////////////////////////////
	// Outputs
	//////////////////////////////

	assign rd.empty    = empty;
	assign rd.rd_valid = read_q;

	// Credit pulse per freed entry, same cycle as rd_valid
	assign in_credit   = read_q;

endmodule

//--- verilog/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram (
	input  logic              clock,
	input  logic              wr_en,
	input  buffer_pkg::addr_t wr_addr,
	input  buffer_pkg::word_t wr_data,
	input  logic              rd_en,
	input  buffer_pkg::addr_t rd_addr,
	output buffer_pkg::word_t rd_data
);

	//////////////////////////////
	// Storage
	//////////////////////////////

	// One slot per FIFO entry
	buffer_pkg::word_t mem [buffer_pkg::fifo_depth];

	//////////////////////////////
	// Write port
	//////////////////////////////

	// Word lands at the edge where wr_en is high
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	//////////////////////////////
	// Read port
	//////////////////////////////

	// Registered read, output holds between reads
	// Same-slot read and write at one edge returns the old word
	always_ff @(posedge clock) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

//--- verilog/fifo_read_if.sv
`timescale 1ns/1ps

// Read side of the FIFO, controller to credit sender
interface fifo_read_if;

	// Request for the oldest entry
	logic pop;

	// No entry visible to the sender
	logic empty;

	// Word from an accepted pop, one cycle later
	logic rd_valid;
	buffer_pkg::word_t rd_data;

	// FIFO side
	modport ctrl (
		input  pop,
		output empty,
		output rd_valid,
		output rd_data
	);

	// Sender side
	modport sender (
		output pop,
		input  empty,
		input  rd_valid,
		input  rd_data
	);

endinterface

//--- verilog/buffer_pkg.sv
package buffer_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	// One stream word
	localparam int data_width = 16;

	// RAM slot index
	localparam int addr_width = 4;

	// Entries in the circular FIFO, also the upstream credit at reset
	localparam int fifo_depth = 1 << addr_width;

	// Downstream allowance after reset
	localparam int out_credits = 4;

	//////////////////////////////
	// Vector types
	//////////////////////////////

	typedef logic [data_width-1:0] word_t;
	typedef logic [addr_width-1:0] addr_t;

	// Slot index plus wrap bit on top
	typedef logic [addr_width:0] ptr_t;

	// Wide enough for out_credits
	typedef logic [2:0] credit_t;

endpackage
